//--- logic/arcade_pkg.sv
// Arcade I/O shared definitions
`default_nettype none

package arcade_pkg;

	// ------------------------------
	// vector types
	typedef logic [10:0] ps2_key_t;       // toggle, pressed, code
	typedef logic [7:0]  key_code_t;
	typedef logic [7:0]  joy_t;
	typedef logic [31:0] status_t;
	typedef logic [1:0]  board_buttons_t;
	typedef logic [1:0]  color2_t;
	typedef logic [5:0]  color6_t;
	typedef logic [11:0] audio_t;         // unsigned
	typedef logic [1:0]  scanline_t;

	// ------------------------------
	// ps2 event fields
	localparam int ps2_toggle  = 10;
	localparam int ps2_pressed = 9;

	// scan codes, set 2
	localparam key_code_t key_up     = 8'h75;
	localparam key_code_t key_down   = 8'h72;
	localparam key_code_t key_left   = 8'h6B;
	localparam key_code_t key_right  = 8'h74;
	localparam key_code_t key_coin   = 8'h76; // esc
	localparam key_code_t key_start1 = 8'h05; // f1
	localparam key_code_t key_start2 = 8'h06; // f2
	localparam key_code_t key_fire1  = 8'h29; // space
	localparam key_code_t key_fire2  = 8'h11; // alt

	// ------------------------------
	// joystick bit positions
	localparam int joy_right   = 0;
	localparam int joy_left    = 1;
	localparam int joy_down    = 2;
	localparam int joy_up      = 3;
	localparam int joy_fire    = 4;
	localparam int joy_barrier = 5;

	// status word and board button bits
	localparam int st_reset   = 0;
	localparam int st_rotate  = 2;        // 0 selects rotated controls
	localparam int st_scan_lo = 3;        // scanlines in 4..3
	localparam int st_reset2  = 6;
	localparam int bb_reset   = 1;

endpackage

`default_nettype wire

//--- logic/key_latch.sv
// PS/2 key event latch
`timescale 1ns/1ns
`default_nettype none

module key_latch (
	input  wire                 clk_mist,
	input  wire                 rst,
	input  wire arcade_pkg::ps2_key_t ps2_key,
	output logic                btn_up,
	output logic                btn_down,
	output logic                btn_left,
	output logic                btn_right,
	output logic                btn_coin,
	output logic                btn_start1,
	output logic                btn_start2,
	output logic                btn_fire1,
	output logic                btn_fire2
);

	import arcade_pkg::*;

	logic      toggle_q;
	logic      new_event;
	logic      pressed;
	key_code_t code;

	assign code      = ps2_key[7:0];
	assign pressed   = ps2_key[ps2_pressed];
	assign new_event = (ps2_key[ps2_toggle] != toggle_q);

	// follows the toggle every cycle, so no event is seen out of reset
	always_ff @(posedge clk_mist) begin
		toggle_q <= ps2_key[ps2_toggle];
	end

	// ------------------------------
	// button levels
	always_ff @(posedge clk_mist) begin
		if (rst) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
			btn_fire1  <= 1'b0;
			btn_fire2  <= 1'b0;
		end else if (new_event) begin
			case (code)
				key_up:     btn_up     <= pressed;
				key_down:   btn_down   <= pressed;
				key_left:   btn_left   <= pressed;
				key_right:  btn_right  <= pressed;
				key_coin:   btn_coin   <= pressed;
				key_start1: btn_start1 <= pressed;
				key_start2: btn_start2 <= pressed;
				key_fire1:  btn_fire1  <= pressed;
				key_fire2:  btn_fire2  <= pressed;
				default: ; // other keys ignored
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/control_mapper.sv
// Game control mapper
`timescale 1ns/1ns
`default_nettype none

module control_mapper (
	input  wire                  clk_mist,
	input  wire                  rst,
	input  wire                  btn_up,
	input  wire                  btn_down,
	input  wire                  btn_left,
	input  wire                  btn_right,
	input  wire                  btn_coin,
	input  wire                  btn_start1,
	input  wire                  btn_start2,
	input  wire                  btn_fire1,
	input  wire                  btn_fire2,
	input  wire arcade_pkg::joy_t    joystick_0,
	input  wire arcade_pkg::joy_t    joystick_1,
	input  wire arcade_pkg::status_t status,
	output logic                 game_left,
	output logic                 game_right,
	output logic                 game_fire,
	output logic                 game_barrier,
	output logic                 game_coin,
	output logic                 game_start1,
	output logic                 game_start2
);

	import arcade_pkg::*;

	logic rotated;
	logic left_src;
	logic right_src;
	logic fire_src;
	logic barrier_src;

	assign rotated = ~status[st_rotate];

	// rotated cabinet: down/up become left/right
	assign left_src = rotated ?
		(btn_down | joystick_0[joy_down] | joystick_1[joy_down]) :
		(btn_left | joystick_0[joy_left] | joystick_1[joy_left]);
	assign right_src = rotated ?
		(btn_up | joystick_0[joy_up] | joystick_1[joy_up]) :
		(btn_right | joystick_0[joy_right] | joystick_1[joy_right]);

	assign fire_src    = btn_fire1 | joystick_0[joy_fire] | joystick_1[joy_fire];
	assign barrier_src = btn_fire2 | joystick_0[joy_barrier] | joystick_1[joy_barrier];

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			game_left    <= 1'b0;
			game_right   <= 1'b0;
			game_fire    <= 1'b0;
			game_barrier <= 1'b0;
			game_coin    <= 1'b0;
			game_start1  <= 1'b0;
			game_start2  <= 1'b0;
		end else begin
			game_left    <= left_src;
			game_right   <= right_src;
			game_fire    <= fire_src;
			game_barrier <= barrier_src;
			game_coin    <= btn_coin;   // straight through
			game_start1  <= btn_start1;
			game_start2  <= btn_start2;
		end
	end

endmodule

`default_nettype wire

//--- logic/reset_stretch.sv
// Game reset stretcher
`timescale 1ns/1ns
`default_nettype none

module reset_stretch #(
	parameter int reset_hold = 8
) (
	input  wire                         clk_mist,
	input  wire                         rst,
	input  wire arcade_pkg::status_t        status,
	input  wire arcade_pkg::board_buttons_t buttons,
	output logic                        game_reset
);

	import arcade_pkg::*;

	localparam int cnt_w = $clog2(reset_hold + 1);

	logic             request;
	logic [cnt_w-1:0] hold_cnt;

	// osd reset, osd reset entry, board button
	assign request = status[st_reset] | status[st_reset2] | buttons[bb_reset];

	// ------------------------------
	// hold counter, reloaded while a request lasts
	always_ff @(posedge clk_mist) begin
		if (rst || request) begin
			hold_cnt <= cnt_w'(reset_hold);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - cnt_w'(1);
		end
	end

	// registered, one cycle behind the request
	always_ff @(posedge clk_mist) begin
		if (rst) begin
			game_reset <= 1'b1;
		end else begin
			game_reset <= request | (hold_cnt != '0);
		end
	end

endmodule

`default_nettype wire

//--- logic/pixel_blanker.sv
// Video blanking and colour widening
`timescale 1ns/1ns
`default_nettype none

module pixel_blanker (
	input  wire                    clk_mist,
	input  wire                    rst,
	input  wire arcade_pkg::color2_t   r_in,
	input  wire arcade_pkg::color2_t   g_in,
	input  wire arcade_pkg::color2_t   b_in,
	input  wire                    hs_in,
	input  wire                    vs_in,
	input  wire                    hblank_bg,
	input  wire                    hblank_fg,
	input  wire                    vblank,
	input  wire arcade_pkg::status_t   status,
	input  wire                    scandoubler_d,
	output arcade_pkg::color6_t    vga_r,
	output arcade_pkg::color6_t    vga_g,
	output arcade_pkg::color6_t    vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output arcade_pkg::scanline_t  scanlines
);

	import arcade_pkg::*;

	logic blank;

	assign blank = hblank_bg | hblank_fg | vblank; // either layer or vertical

	// ------------------------------
	// colour, syncs and scanlines share one register stage
	always_ff @(posedge clk_mist) begin
		if (rst) begin
			vga_r     <= '0;
			vga_g     <= '0;
			vga_b     <= '0;
			vga_hs    <= 1'b0;
			vga_vs    <= 1'b0;
			scanlines <= '0;
		end else begin
			vga_r  <= blank ? color6_t'(0) : {3{r_in}};
			vga_g  <= blank ? color6_t'(0) : {3{g_in}};
			vga_b  <= blank ? color6_t'(0) : {3{b_in}};
			vga_hs <= hs_in;
			vga_vs <= vs_in;
			// no scanlines on the 15 kHz path
			scanlines <= scandoubler_d ? scanline_t'(0) :
				status[st_scan_lo +: $bits(scanline_t)];
		end
	end

endmodule

`default_nettype wire

//--- logic/sigma_delta_dac.sv
// First-order sigma-delta audio DAC
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac #(
	parameter int dac_bits = 16
) (
	input  wire                 clk_mist,
	input  wire                 rst,
	input  wire arcade_pkg::audio_t audio,
	output logic                audio_out
);

	import arcade_pkg::*;

	localparam int pad_bits = dac_bits - $bits(audio_t);

	logic [dac_bits-1:0] din;
	logic [dac_bits-1:0] acc;
	logic [dac_bits:0]   sum;

	assign din = {audio, {pad_bits{1'b0}}}; // sample in the top bits
	assign sum = {1'b0, acc} + {1'b0, din};

	// ------------------------------
	// carry out is the pulse density
	always_ff @(posedge clk_mist) begin
		if (rst) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= sum[dac_bits-1:0];
			audio_out <= sum[dac_bits];
		end
	end

endmodule

`default_nettype wire

//--- logic/arcade_io_top.sv
// Arcade board I/O glue top
`timescale 1ns/1ns
`default_nettype none

module arcade_io_top #(
	parameter int dac_bits   = 16,
	parameter int reset_hold = 8
) (
	input  wire                         clk_mist,
	input  wire                         rst,
	input  wire arcade_pkg::ps2_key_t       ps2_key,
	input  wire arcade_pkg::joy_t           joystick_0,
	input  wire arcade_pkg::joy_t           joystick_1,
	input  wire arcade_pkg::status_t        status,
	input  wire arcade_pkg::board_buttons_t buttons,
	input  wire                         scandoubler_d,
	input  wire arcade_pkg::color2_t        r_in,
	input  wire arcade_pkg::color2_t        g_in,
	input  wire arcade_pkg::color2_t        b_in,
	input  wire                         hs_in,
	input  wire                         vs_in,
	input  wire                         hblank_bg,
	input  wire                         hblank_fg,
	input  wire                         vblank,
	input  wire arcade_pkg::audio_t         audio,
	output logic                        game_left,
	output logic                        game_right,
	output logic                        game_fire,
	output logic                        game_barrier,
	output logic                        game_coin,
	output logic                        game_start1,
	output logic                        game_start2,
	output logic                        game_reset,
	output arcade_pkg::color6_t         vga_r,
	output arcade_pkg::color6_t         vga_g,
	output arcade_pkg::color6_t         vga_b,
	output logic                        vga_hs,
	output logic                        vga_vs,
	output arcade_pkg::scanline_t       scanlines,
	output logic                        audio_out
);

	// keyboard button levels
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;
	logic btn_fire1;
	logic btn_fire2;

	// ------------------------------
	// controls
	key_latch u_key_latch (
		.clk_mist   (clk_mist),
		.rst        (rst),
		.ps2_key    (ps2_key),
		.btn_up     (btn_up),
		.btn_down   (btn_down),
		.btn_left   (btn_left),
		.btn_right  (btn_right),
		.btn_coin   (btn_coin),
		.btn_start1 (btn_start1),
		.btn_start2 (btn_start2),
		.btn_fire1  (btn_fire1),
		.btn_fire2  (btn_fire2)
	);

	control_mapper u_control_mapper (
		.clk_mist     (clk_mist),
		.rst          (rst),
		.btn_up       (btn_up),
		.btn_down     (btn_down),
		.btn_left     (btn_left),
		.btn_right    (btn_right),
		.btn_coin     (btn_coin),
		.btn_start1   (btn_start1),
		.btn_start2   (btn_start2),
		.btn_fire1    (btn_fire1),
		.btn_fire2    (btn_fire2),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.game_left    (game_left),
		.game_right   (game_right),
		.game_fire    (game_fire),
		.game_barrier (game_barrier),
		.game_coin    (game_coin),
		.game_start1  (game_start1),
		.game_start2  (game_start2)
	);

	reset_stretch #(
		.reset_hold (reset_hold)
	) u_reset_stretch (
		.clk_mist   (clk_mist),
		.rst        (rst),
		.status     (status),
		.buttons    (buttons),
		.game_reset (game_reset)
	);

	// ------------------------------
	// video and audio
	pixel_blanker u_pixel_blanker (
		.clk_mist      (clk_mist),
		.rst           (rst),
		.r_in          (r_in),
		.g_in          (g_in),
		.b_in          (b_in),
		.hs_in         (hs_in),
		.vs_in         (vs_in),
		.hblank_bg     (hblank_bg),
		.hblank_fg     (hblank_fg),
		.vblank        (vblank),
		.status        (status),
		.scandoubler_d (scandoubler_d),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs),
		.scanlines     (scanlines)
	);

	sigma_delta_dac #(
		.dac_bits (dac_bits)
	) u_sigma_delta_dac (
		.clk_mist  (clk_mist),
		.rst       (rst),
		.audio     (audio),
		.audio_out (audio_out) // same stream feeds both channels on the board
	);

endmodule

`default_nettype wire

//--- dv/arcade_io_checker.sv
// Arcade I/O assertion checker
`timescale 1ns/1ns
`default_nettype none

module arcade_io_checker (
	input wire                             clk_mist,
	input wire                             rst,
	input wire arcade_pkg::status_t        status,
	input wire arcade_pkg::board_buttons_t buttons,
	input wire                             hblank_bg,
	input wire                             hblank_fg,
	input wire                             vblank,
	input wire                             game_left,
	input wire                             game_right,
	input wire                             game_reset,
	input wire arcade_pkg::color6_t        vga_r,
	input wire arcade_pkg::color6_t        vga_g,
	input wire arcade_pkg::color6_t        vga_b
);

	import arcade_pkg::*;

	int unsigned fail_count = 0;
	logic        request;
	logic        blank;

	assign request = status[st_reset] | status[st_reset2] | buttons[bb_reset];
	assign blank   = hblank_bg | hblank_fg | vblank;

	// ------------------------------
	ctl_clear_after_rst: assert property (@(posedge clk_mist)
		rst |=> (!game_left && !game_right))
		else begin
			$error("direction controls not cleared after rst");
			fail_count++;
		end

	reset_held_by_request: assert property (@(posedge clk_mist)
		request |=> game_reset)
		else begin
			$error("game_reset low while a reset request is present");
			fail_count++;
		end

	// blank wins over colour, one register stage later
	color_zero_in_blank: assert property (@(posedge clk_mist)
		blank |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else begin
			$error("colour not zero after blanking");
			fail_count++;
		end

endmodule

bind arcade_io_top arcade_io_checker u_arcade_io_checker (
	.clk_mist   (clk_mist),
	.rst        (rst),
	.status     (status),
	.buttons    (buttons),
	.hblank_bg  (hblank_bg),
	.hblank_fg  (hblank_fg),
	.vblank     (vblank),
	.game_left  (game_left),
	.game_right (game_right),
	.game_reset (game_reset),
	.vga_r      (vga_r),
	.vga_g      (vga_g),
	.vga_b      (vga_b)
);

`default_nettype wire

//--- dv/arcade_io_tb.sv
// Arcade I/O testbench
`timescale 1ns/1ns
`default_nettype none

module arcade_io_tb;

	import arcade_pkg::*;

	localparam int dac_bits   = 16;
	localparam int reset_hold = 8;
	localparam int window     = 1 << dac_bits; // one full accumulator period

	logic           clk_mist;
	logic           rst;
	ps2_key_t       ps2_key;
	joy_t           joystick_0;
	joy_t           joystick_1;
	status_t        status;
	board_buttons_t buttons;
	logic           scandoubler_d;
	color2_t        r_in;
	color2_t        g_in;
	color2_t        b_in;
	logic           hs_in;
	logic           vs_in;
	logic           hblank_bg;
	logic           hblank_fg;
	logic           vblank;
	audio_t         audio;
	logic           game_left;
	logic           game_right;
	logic           game_fire;
	logic           game_barrier;
	logic           game_coin;
	logic           game_start1;
	logic           game_start2;
	logic           game_reset;
	color6_t        vga_r;
	color6_t        vga_g;
	color6_t        vga_b;
	logic           vga_hs;
	logic           vga_vs;
	scanline_t      scanlines;
	logic           audio_out;

	// key model, same order as key_list
	key_code_t key_list [9] = '{key_up, key_down, key_left, key_right, key_coin,
		key_start1, key_start2, key_fire1, key_fire2};
	logic      btn_m [9];
	logic      toggle_bit;

	arcade_io_top #(
		.dac_bits   (dac_bits),
		.reset_hold (reset_hold)
	) u_dut (.*);

	initial begin
		clk_mist = 1'b0;
		forever #20 clk_mist = ~clk_mist;
	end

	// ------------------------------
	// failure reporting and compares
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %b actual %b",
				$time, name, exp, act));
	endtask

	task automatic check_color(input string name, input color6_t exp, input color6_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h actual %h",
				$time, name, exp, act));
	endtask

	task automatic check_scan(input string name, input scanline_t exp, input scanline_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %0d actual %0d",
				$time, name, exp, act));
	endtask

	task automatic check_density(input string name, input int unsigned exp,
		input int unsigned act);
		if (act != exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %0d actual %0d",
				$time, name, exp, act));
	endtask

	// ------------------------------
	// control model
	function automatic int key_index(input key_code_t code);
		int idx;
		idx = -1;
		foreach (key_list[i]) begin
			if (key_list[i] == code) idx = i;
		end
		return idx;
	endfunction

	// {left, right, fire, barrier, coin, start1, start2}
	function automatic logic [6:0] expected_controls(input logic rot_bit, input joy_t j0,
		input joy_t j1);
		joy_t j;
		logic l;
		logic r;
		j = j0 | j1;
		l = rot_bit ? (btn_m[2] | j[joy_left]) : (btn_m[1] | j[joy_down]);
		r = rot_bit ? (btn_m[3] | j[joy_right]) : (btn_m[0] | j[joy_up]);
		return {l, r, btn_m[7] | j[joy_fire], btn_m[8] | j[joy_barrier],
			btn_m[4], btn_m[5], btn_m[6]};
	endfunction

	task automatic check_controls();
		logic [6:0] exp;
		exp = expected_controls(status[st_rotate], joystick_0, joystick_1);
		check_bit("game_left", exp[6], game_left);
		check_bit("game_right", exp[5], game_right);
		check_bit("game_fire", exp[4], game_fire);
		check_bit("game_barrier", exp[3], game_barrier);
		check_bit("game_coin", exp[2], game_coin);
		check_bit("game_start1", exp[1], game_start1);
		check_bit("game_start2", exp[0], game_start2);
	endtask

	function automatic color6_t widen(input color2_t c, input logic blank);
		return blank ? color6_t'(0) : {c, c, c};
	endfunction

	// ------------------------------
	// directed tests
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (game_reset !== 1'b0 && cycles < 100) begin
			@(negedge clk_mist);
			cycles++;
		end
		if (game_reset !== 1'b0) abort_run("game_reset never fell after the power-on reset");
	endtask

	task automatic send_key(input key_code_t code, input logic press, input logic flip);
		int idx;
		idx = key_index(code);
		if (flip) toggle_bit = ~toggle_bit;
		if (flip && idx >= 0) btn_m[idx] = press;
		@(posedge clk_mist);
		ps2_key <= {toggle_bit, press, 1'b0, code};
		repeat (2) @(posedge clk_mist); // latch, then mapper
		@(negedge clk_mist);
		check_controls();
	endtask

	task automatic test_keys();
		status_t s;
		for (int rot = 0; rot < 2; rot++) begin
			s = '0;
			s[st_rotate] = rot[0];
			@(posedge clk_mist);
			status <= s;
			foreach (key_list[i]) begin
				send_key(key_list[i], 1'b1, 1'b1);
				send_key(key_list[i], 1'b0, 1'b1);
			end
			send_key(key_fire1, 1'b1, 1'b1);
			send_key(key_fire1, 1'b0, 1'b0); // stale toggle, fire stays held
			send_key(8'h1C, 1'b1, 1'b1);     // unknown code
			send_key(key_fire1, 1'b0, 1'b1);
		end
	endtask

	task automatic test_joysticks();
		status_t s;
		for (int rot = 0; rot < 2; rot++) begin
			s = '0;
			s[st_rotate] = rot[0];
			repeat (16) begin
				@(posedge clk_mist);
				status     <= s;
				joystick_0 <= joy_t'($urandom);
				joystick_1 <= joy_t'($urandom);
				@(posedge clk_mist);
				@(negedge clk_mist);
				check_controls();
			end
		end
		@(posedge clk_mist);
		joystick_0 <= '0;
		joystick_1 <= '0;
	endtask

	task automatic pulse_reset(input int source);
		status_t        s_req;
		board_buttons_t b_req;
		s_req = '0;
		b_req = '0;
		case (source)
			0:       s_req[st_reset] = 1'b1;
			1:       s_req[st_reset2] = 1'b1;
			default: b_req[bb_reset] = 1'b1;
		endcase
		@(posedge clk_mist);
		status  <= s_req;
		buttons <= b_req;
		@(negedge clk_mist);
		check_bit("game_reset", 1'b0, game_reset);
		repeat (4) begin
			@(posedge clk_mist);
			@(negedge clk_mist);
			check_bit("game_reset", 1'b1, game_reset);
		end
		@(posedge clk_mist);
		status  <= '0;
		buttons <= '0;
		// one register stage, then the hold count
		repeat (reset_hold) begin
			@(posedge clk_mist);
			@(negedge clk_mist);
			check_bit("game_reset", 1'b1, game_reset);
		end
		@(posedge clk_mist);
		@(negedge clk_mist);
		check_bit("game_reset", 1'b0, game_reset);
	endtask

	task automatic test_video();
		color2_t r;
		color2_t g;
		color2_t b;
		status_t s;
		for (int bl = 0; bl < 8; bl++) begin
			for (int sy = 0; sy < 4; sy++) begin
				r = color2_t'($urandom);
				g = color2_t'($urandom);
				b = color2_t'($urandom);
				@(posedge clk_mist);
				r_in <= r;
				g_in <= g;
				b_in <= b;
				{hblank_bg, hblank_fg, vblank} <= bl[2:0];
				{hs_in, vs_in} <= sy[1:0];
				@(posedge clk_mist);
				@(negedge clk_mist);
				check_color("vga_r", widen(r, bl != 0), vga_r);
				check_color("vga_g", widen(g, bl != 0), vga_g);
				check_color("vga_b", widen(b, bl != 0), vga_b);
				check_bit("vga_hs", sy[1], vga_hs);
				check_bit("vga_vs", sy[0], vga_vs);
			end
		end
		for (int sd = 0; sd < 2; sd++) begin
			for (int sc = 0; sc < 4; sc++) begin
				s = '0;
				s[st_scan_lo +: 2] = sc[1:0];
				@(posedge clk_mist);
				status        <= s;
				scandoubler_d <= sd[0];
				@(posedge clk_mist);
				@(negedge clk_mist);
				check_scan("scanlines", sd[0] ? scanline_t'(0) : scanline_t'(sc), scanlines);
			end
		end
		@(posedge clk_mist);
		{hblank_bg, hblank_fg, vblank} <= 3'b000;
		status        <= '0;
		scandoubler_d <= 1'b0;
	endtask

	task automatic test_audio();
		audio_t      sample;
		int unsigned ones;
		repeat (3) begin
			sample = audio_t'($urandom);
			ones   = 0;
			@(posedge clk_mist);
			audio <= sample;
			repeat (window) @(posedge clk_mist); // settle
			repeat (window) begin
				@(negedge clk_mist);
				if (audio_out) ones++;
			end
			check_density("audio_out ones", int'(sample) << (dac_bits - $bits(audio_t)), ones);
		end
	endtask

	// ------------------------------
	// main sequence
	initial begin
		void'($urandom(32'h9ac2_41c6));
		rst           = 1'b1;
		ps2_key       = '0;
		joystick_0    = '0;
		joystick_1    = '0;
		status        = '0;
		buttons       = '0;
		scandoubler_d = 1'b0;
		r_in          = '0;
		g_in          = '0;
		b_in          = '0;
		hs_in         = 1'b0;
		vs_in         = 1'b0;
		hblank_bg     = 1'b0;
		hblank_fg     = 1'b0;
		vblank        = 1'b0;
		audio         = '0;
		toggle_bit    = 1'b0;
		foreach (btn_m[i]) btn_m[i] = 1'b0;
		repeat (5) @(posedge clk_mist);
		rst <= 1'b0;
		@(negedge clk_mist);
		check_bit("game_left", 1'b0, game_left);
		check_bit("game_right", 1'b0, game_right);
		wait_reset_release();
		test_keys();
		test_joysticks();
		for (int src = 0; src < 3; src++) pulse_reset(src);
		test_video();
		test_audio();
		if (u_dut.u_arcade_io_checker.fail_count != 0) begin
			abort_run("the bound checker saw assertion failures");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
logic/arcade_pkg.sv
logic/key_latch.sv
logic/control_mapper.sv
logic/reset_stretch.sv
logic/pixel_blanker.sv
logic/sigma_delta_dac.sv
logic/arcade_io_top.sv
dv/arcade_io_checker.sv
dv/arcade_io_tb.sv

//--- Makefile
# Verilator build and run for the arcade I/O testbench

VERILATOR ?= verilator
TOP       ?= arcade_io_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
